/* hdl/tomasuloPkg.sv */
package tomasuloPkg;

    localparam int DataW = 32;
    localparam int NickW = 3;
    localparam int RobDepth = 2 ** NickW; // one entry per nick, so the tag wraps with the buffer.
    localparam int RsDepth = 4;

    localparam logic Jump = 1'b1;
    localparam logic NotJump = 1'b0;

    typedef logic [DataW-1:0] dataT;
    typedef logic [DataW-1:0] addrT;
    typedef logic [NickW-1:0] nickT;
    typedef logic [$clog2(RsDepth)-1:0] rsIdxT;

    typedef enum logic [4:0] {
        OpLui, // upper immediate and jumps.
        OpAuipc,
        OpJal,
        OpJalr,
        OpBeq, // branches.
        OpBne,
        OpBlt,
        OpBge,
        OpBltu,
        OpBgeu,
        OpAddi, // immediate ALU ops.
        OpSlti,
        OpSltiu,
        OpXori,
        OpOri,
        OpAndi,
        OpSlli,
        OpSrli,
        OpSrai,
        OpAdd, // register ALU ops.
        OpSub,
        OpSll,
        OpSlt,
        OpSltu,
        OpXor,
        OpSrl,
        OpSra,
        OpOr,
        OpAnd
    } opT;

endpackage

/* hdl/resStation.sv */
`timescale 1ns/100ps

module resStation (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              disp,
    input  tomasuloPkg::opT   dispOp,
    input  tomasuloPkg::addrT dispPc,
    input  tomasuloPkg::dataT dispImm,
    input  tomasuloPkg::nickT dispNick,
    input  logic              dispRs1Busy,
    input  tomasuloPkg::dataT dispRs1Val,
    input  tomasuloPkg::nickT dispRs1Nick,
    input  logic              dispRs2Busy,
    input  tomasuloPkg::dataT dispRs2Val,
    input  tomasuloPkg::nickT dispRs2Nick,
    input  logic              robRs1Done,
    input  tomasuloPkg::dataT robRs1Val,
    input  logic              robRs2Done,
    input  tomasuloPkg::dataT robRs2Val,
    input  logic              cdbEn,
    input  tomasuloPkg::nickT cdbNick,
    input  tomasuloPkg::dataT cdbData,
    output tomasuloPkg::nickT robRs1Nick,
    output tomasuloPkg::nickT robRs2Nick,
    output logic              rsFull,
    output logic              issue,
    output tomasuloPkg::opT   issueOp,
    output tomasuloPkg::addrT issuePc,
    output tomasuloPkg::dataT issueImm,
    output tomasuloPkg::nickT issueNick,
    output tomasuloPkg::dataT issueRs1,
    output tomasuloPkg::dataT issueRs2
);
    import tomasuloPkg::*;

    logic  valid [RsDepth];
    rsIdxT age [RsDepth]; // number of younger entries still waiting.
    opT    op [RsDepth];
    addrT  pc [RsDepth];
    dataT  imm [RsDepth];
    nickT  nick [RsDepth];
    logic  busy1 [RsDepth];
    logic  busy2 [RsDepth];
    nickT  tag1 [RsDepth];
    nickT  tag2 [RsDepth];
    dataT  val1 [RsDepth];
    dataT  val2 [RsDepth];

    rsIdxT issueIdx;
    rsIdxT freeIdx;
    logic [$clog2(RsDepth):0] freeCnt;
    logic  rs1Hit, rs2Hit;
    logic  rs1Wait, rs2Wait;

    function automatic dataT pickOperand(logic busy, dataT dispVal, logic cdbHit,
                                         dataT busVal, dataT robVal);
        if (!busy) return dispVal;
        if (cdbHit) return busVal; // producer is on the bus right now.
        return robVal;
    endfunction

    assign robRs1Nick = dispRs1Nick;
    assign robRs2Nick = dispRs2Nick;
    assign rs1Hit = cdbEn && dispRs1Nick == cdbNick;
    assign rs2Hit = cdbEn && dispRs2Nick == cdbNick;
    assign rs1Wait = dispRs1Busy && !rs1Hit && !robRs1Done;
    assign rs2Wait = dispRs2Busy && !rs2Hit && !robRs2Done;

    always_comb begin
        issue = 1'b0;
        issueIdx = '0;
        freeIdx = '0;
        freeCnt = '0;
        for (int i = RsDepth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                freeIdx = rsIdxT'(i); // lowest free slot wins.
                freeCnt = freeCnt + 1'b1;
            end
        end
        for (int i = 0; i < RsDepth; i++) begin
            if (valid[i] && !busy1[i] && !busy2[i] && (!issue || age[i] > age[issueIdx])) begin
                issue = 1'b1;
                issueIdx = rsIdxT'(i);
            end
        end
    end

    assign rsFull = freeCnt == '0;
    assign issueOp = op[issueIdx];
    assign issuePc = pc[issueIdx];
    assign issueImm = imm[issueIdx];
    assign issueNick = nick[issueIdx];
    assign issueRs1 = val1[issueIdx];
    assign issueRs2 = val2[issueIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RsDepth; i++) begin
                valid[i] <= 1'b0;
                age[i] <= '0;
            end
        end else if (rdy) begin
            for (int i = 0; i < RsDepth; i++) begin
                if (valid[i]) begin
                    if (issue && rsIdxT'(i) == issueIdx) valid[i] <= 1'b0;
                    age[i] <= age[i] + rsIdxT'(disp) - rsIdxT'(issue && age[i] > age[issueIdx]);
                    if (cdbEn && busy1[i] && tag1[i] == cdbNick) begin
                        busy1[i] <= 1'b0;
                        val1[i] <= cdbData;
                    end
                    if (cdbEn && busy2[i] && tag2[i] == cdbNick) begin
                        busy2[i] <= 1'b0;
                        val2[i] <= cdbData;
                    end
                end
            end
            if (disp) begin
                valid[freeIdx] <= 1'b1;
                age[freeIdx] <= '0;
                op[freeIdx] <= dispOp;
                pc[freeIdx] <= dispPc;
                imm[freeIdx] <= dispImm;
                nick[freeIdx] <= dispNick;
                busy1[freeIdx] <= rs1Wait;
                busy2[freeIdx] <= rs2Wait;
                tag1[freeIdx] <= dispRs1Nick;
                tag2[freeIdx] <= dispRs2Nick;
                val1[freeIdx] <= pickOperand(dispRs1Busy, dispRs1Val, rs1Hit, cdbData, robRs1Val);
                val2[freeIdx] <= pickOperand(dispRs2Busy, dispRs2Val, rs2Hit, cdbData, robRs2Val);
            end
        end
    end

    dispNotFull: assert property (@(posedge clk) disable iff (rst) disp |-> rdy && !rsFull);
    issueOperandsKnown: assert property (@(posedge clk) disable iff (rst)
        issue |-> valid[issueIdx] && !busy1[issueIdx] && !busy2[issueIdx]);

endmodule

/* hdl/execUnit.sv */
`timescale 1ns/100ps

module execUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              issue,
    input  tomasuloPkg::opT   issueOp,
    input  tomasuloPkg::addrT issuePc,
    input  tomasuloPkg::dataT issueImm,
    input  tomasuloPkg::nickT issueNick,
    input  tomasuloPkg::dataT issueRs1,
    input  tomasuloPkg::dataT issueRs2,
    output logic              cdbEn,
    output tomasuloPkg::nickT cdbNick,
    output tomasuloPkg::dataT cdbData,
    output logic              cdbJump,
    output tomasuloPkg::addrT cdbJumpPc
);
    import tomasuloPkg::*;

    dataT resData;
    logic resJump;
    addrT resTarget;
    dataT jalrSum;

    assign jalrSum = issueRs1 + issueImm;

    always_comb begin
        resData = '0;
        resJump = NotJump;
        resTarget = issuePc + issueImm; // shared by JAL and every taken branch.
        case (issueOp)
            OpLui: resData = issueImm;
            OpAuipc: resData = issuePc + issueImm;
            OpJal: begin
                resData = issuePc + 32'd4;
                resJump = Jump;
            end
            OpJalr: begin
                resData = issuePc + 32'd4;
                resJump = Jump;
                resTarget = {jalrSum[31:1], 1'b0};
            end
            OpBeq: resJump = issueRs1 == issueRs2 ? Jump : NotJump;
            OpBne: resJump = issueRs1 != issueRs2 ? Jump : NotJump;
            OpBlt: resJump = $signed(issueRs1) < $signed(issueRs2) ? Jump : NotJump;
            OpBge: resJump = $signed(issueRs1) >= $signed(issueRs2) ? Jump : NotJump;
            OpBltu: resJump = issueRs1 < issueRs2 ? Jump : NotJump;
            OpBgeu: resJump = issueRs1 >= issueRs2 ? Jump : NotJump;
            OpAddi: resData = issueRs1 + issueImm;
            OpSlti: resData = dataT'($signed(issueRs1) < $signed(issueImm));
            OpSltiu: resData = dataT'(issueRs1 < issueImm);
            OpXori: resData = issueRs1 ^ issueImm;
            OpOri: resData = issueRs1 | issueImm;
            OpAndi: resData = issueRs1 & issueImm;
            OpSlli: resData = issueRs1 << issueImm[4:0]; // only five bits of shift on 32-bit data.
            OpSrli: resData = issueRs1 >> issueImm[4:0];
            OpSrai: resData = dataT'($signed(issueRs1) >>> issueImm[4:0]);
            OpAdd: resData = issueRs1 + issueRs2;
            OpSub: resData = issueRs1 - issueRs2;
            OpSll: resData = issueRs1 << issueRs2[4:0];
            OpSlt: resData = dataT'($signed(issueRs1) < $signed(issueRs2));
            OpSltu: resData = dataT'(issueRs1 < issueRs2);
            OpXor: resData = issueRs1 ^ issueRs2;
            OpSrl: resData = issueRs1 >> issueRs2[4:0];
            OpSra: resData = dataT'($signed(issueRs1) >>> issueRs2[4:0]);
            OpOr: resData = issueRs1 | issueRs2;
            OpAnd: resData = issueRs1 & issueRs2;
            default: resData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdbEn <= 1'b0;
        end else if (rdy) begin
            cdbEn <= issue; // held while frozen, consumed on the next live edge.
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issue) begin
            cdbNick <= issueNick;
            cdbData <= resData;
            cdbJump <= resJump;
            cdbJumpPc <= resTarget;
        end
    end

    cdbFollowsIssue: assert property (@(posedge clk) disable iff (rst)
        rdy && !issue |=> !cdbEn);

endmodule

/* hdl/reorderBuf.sv */
`timescale 1ns/100ps

module reorderBuf (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              disp,
    input  tomasuloPkg::nickT robRs1Nick,
    input  tomasuloPkg::nickT robRs2Nick,
    input  logic              cdbEn,
    input  tomasuloPkg::nickT cdbNick,
    input  tomasuloPkg::dataT cdbData,
    input  logic              cdbJump,
    input  tomasuloPkg::addrT cdbJumpPc,
    output tomasuloPkg::nickT dispNick,
    output logic              robFull,
    output logic              robRs1Done,
    output tomasuloPkg::dataT robRs1Val,
    output logic              robRs2Done,
    output tomasuloPkg::dataT robRs2Val,
    output logic              commit,
    output tomasuloPkg::nickT commitNick,
    output tomasuloPkg::dataT commitData,
    output logic              commitJump,
    output tomasuloPkg::addrT commitJumpPc
);
    import tomasuloPkg::*;

    logic done [RobDepth];
    dataT data [RobDepth];
    logic jump [RobDepth];
    addrT jumpPc [RobDepth];

    nickT head;
    nickT tail;
    logic [NickW:0] count;

    assign dispNick = tail;
    assign robFull = count == RobDepth;

    // lookups only ever name allocated producers.
    assign robRs1Done = done[robRs1Nick];
    assign robRs1Val = data[robRs1Nick];
    assign robRs2Done = done[robRs2Nick];
    assign robRs2Val = data[robRs2Nick];

    assign commit = rdy && count != '0 && done[head];
    assign commitNick = head;
    assign commitData = data[head];
    assign commitJump = jump[head];
    assign commitJumpPc = jumpPc[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < RobDepth; i++) begin
                done[i] <= 1'b0;
            end
        end else if (rdy) begin
            if (disp) begin
                done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (cdbEn) begin
                done[cdbNick] <= 1'b1;
            end
            if (commit) begin
                head <= head + 1'b1;
            end
            count <= count + (NickW + 1)'(disp) - (NickW + 1)'(commit);
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && cdbEn) begin
            data[cdbNick] <= cdbData;
            jump[cdbNick] <= cdbJump;
            jumpPc[cdbNick] <= cdbJumpPc;
        end
    end

    // an entry is written once, and only between its dispatch and its commit.
    cdbHitsLiveEntry: assert property (@(posedge clk) disable iff (rst)
        rdy && cdbEn |-> nickT'(cdbNick - head) < count && !done[cdbNick]);
    commitOnlyDone: assert property (@(posedge clk) disable iff (rst)
        commit |=> !rdy || $past(count) != '0 && $past(done[head]));

endmodule

/* hdl/execCore.sv */
`timescale 1ns/100ps

module execCore (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              disp,
    input  tomasuloPkg::opT   dispOp,
    input  tomasuloPkg::addrT dispPc,
    input  tomasuloPkg::dataT dispImm,
    input  logic              dispRs1Busy,
    input  tomasuloPkg::dataT dispRs1Val,
    input  tomasuloPkg::nickT dispRs1Nick,
    input  logic              dispRs2Busy,
    input  tomasuloPkg::dataT dispRs2Val,
    input  tomasuloPkg::nickT dispRs2Nick,
    output tomasuloPkg::nickT dispNick,
    output logic              full,
    output logic              commit,
    output tomasuloPkg::nickT commitNick,
    output tomasuloPkg::dataT commitData,
    output logic              commitJump,
    output tomasuloPkg::addrT commitJumpPc
);
    import tomasuloPkg::*;

    nickT robRs1Nick, robRs2Nick;
    logic robRs1Done, robRs2Done;
    dataT robRs1Val, robRs2Val;
    logic rsFull, robFull;
    logic issue;
    opT   issueOp;
    addrT issuePc;
    dataT issueImm, issueRs1, issueRs2;
    nickT issueNick;
    logic cdbEn, cdbJump;
    nickT cdbNick;
    dataT cdbData;
    addrT cdbJumpPc;

    assign full = rsFull || robFull;

    resStation resStation_inst (
        .clk, .rst, .rdy, .disp, .dispOp, .dispPc, .dispImm, .dispNick,
        .dispRs1Busy, .dispRs1Val, .dispRs1Nick, .dispRs2Busy, .dispRs2Val, .dispRs2Nick,
        .robRs1Done, .robRs1Val, .robRs2Done, .robRs2Val, .cdbEn, .cdbNick, .cdbData,
        .robRs1Nick, .robRs2Nick, .rsFull, .issue, .issueOp, .issuePc, .issueImm,
        .issueNick, .issueRs1, .issueRs2
    );

    execUnit execUnit_inst (
        .clk, .rst, .rdy, .issue, .issueOp, .issuePc, .issueImm, .issueNick,
        .issueRs1, .issueRs2, .cdbEn, .cdbNick, .cdbData, .cdbJump, .cdbJumpPc
    );

    reorderBuf reorderBuf_inst (
        .clk, .rst, .rdy, .disp, .robRs1Nick, .robRs2Nick, .cdbEn, .cdbNick, .cdbData,
        .cdbJump, .cdbJumpPc, .dispNick, .robFull, .robRs1Done, .robRs1Val, .robRs2Done,
        .robRs2Val, .commit, .commitNick, .commitData, .commitJump, .commitJumpPc
    );

endmodule

/* dv/execCoreTb.sv */
`timescale 1ns/100ps

module execCoreTb;
    import tomasuloPkg::*;

    localparam int NumRows = 38;
    localparam int BurstStart = 26; // the last 12 rows go back to back with rdy held high.
    localparam int TimeoutCycles = NumRows * 40 + 100;
    localparam int Lit = -1; // a source code of zero or more names the producer row.
    localparam int Rnd = -2;

    logic clk = 1'b0;
    logic rst;
    logic rdy;
    logic disp;
    opT   dispOp;
    addrT dispPc;
    dataT dispImm;
    logic dispRs1Busy;
    dataT dispRs1Val;
    nickT dispRs1Nick;
    logic dispRs2Busy;
    dataT dispRs2Val;
    nickT dispRs2Nick;
    nickT dispNick;
    logic full;
    logic commit;
    nickT commitNick;
    dataT commitData;
    logic commitJump;
    addrT commitJumpPc;

    opT   rowOp [NumRows];
    addrT rowPc [NumRows];
    dataT rowImm [NumRows];
    int   rowSrc1 [NumRows];
    int   rowSrc2 [NumRows];
    dataT rowLit1 [NumRows];
    dataT rowLit2 [NumRows];
    dataT expData [NumRows];
    logic expJump [NumRows];
    addrT expTarget [NumRows];

    logic [31:0] rngState = 32'h6468_b6cf;
    logic [31:0] rnd;
    int tableLen = 0;
    int row = 0;
    int committed = 0;
    int errors = 0;
    int cycles = 0;
    logic sawFull = 1'b0;

    execCore execCore_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic lessSigned(dataT x, dataT y);
        if (x[31] != y[31]) return x[31]; // the negative one is smaller.
        return x < y;
    endfunction

    function automatic dataT shiftArith(dataT x, logic [4:0] n);
        logic [63:0] wide;
        wide = {{32{x[31]}}, x} >> n;
        return wide[31:0];
    endfunction

    task automatic refModel(input opT op, input addrT pc, input dataT imm, input dataT a,
                            input dataT b, output dataT data, output logic jump,
                            output addrT target);
        data = '0;
        jump = NotJump;
        target = pc + imm;
        case (op)
            OpLui: data = imm;
            OpAuipc: data = pc + imm;
            OpJal: begin
                data = pc + 4;
                jump = Jump;
            end
            OpJalr: begin
                data = pc + 4;
                jump = Jump;
                target = (a + imm) & ~32'h1;
            end
            OpBeq: jump = a == b;
            OpBne: jump = a != b;
            OpBlt: jump = lessSigned(a, b);
            OpBge: jump = !lessSigned(a, b);
            OpBltu: jump = a < b;
            OpBgeu: jump = a >= b;
            OpAddi: data = a + imm;
            OpSlti: data = {31'b0, lessSigned(a, imm)};
            OpSltiu: data = {31'b0, a < imm};
            OpXori: data = a ^ imm;
            OpOri: data = a | imm;
            OpAndi: data = a & imm;
            OpSlli: data = a << imm[4:0];
            OpSrli: data = a >> imm[4:0];
            OpSrai: data = shiftArith(a, imm[4:0]);
            OpAdd: data = a + b;
            OpSub: data = a - b;
            OpSll: data = a << b[4:0];
            OpSlt: data = {31'b0, lessSigned(a, b)};
            OpSltu: data = {31'b0, a < b};
            OpXor: data = a ^ b;
            OpSrl: data = a >> b[4:0];
            OpSra: data = shiftArith(a, b[4:0]);
            OpOr: data = a | b;
            OpAnd: data = a & b;
            default: data = '0;
        endcase
    endtask

    task automatic addRow(input opT op, input dataT imm, input int src1, input dataT lit1,
                          input int src2, input dataT lit2);
        dataT a;
        dataT b;
        int r;
        r = tableLen;
        rowOp[r] = op;
        rowPc[r] = 32'h0000_1000 + 32'(r * 4);
        rowImm[r] = imm;
        rowSrc1[r] = src1;
        rowSrc2[r] = src2;
        rowLit1[r] = src1 == Lit ? lit1 : nextRandom(); // busy sources carry a decoy value.
        rowLit2[r] = src2 == Lit ? lit2 : nextRandom();
        a = src1 >= 0 ? expData[src1] : rowLit1[r];
        b = src2 >= 0 ? expData[src2] : rowLit2[r];
        refModel(op, rowPc[r], imm, a, b, expData[r], expJump[r], expTarget[r]);
        tableLen++;
    endtask

    task automatic driveRow(input int r);
        disp = 1'b1;
        dispOp = rowOp[r];
        dispPc = rowPc[r];
        dispImm = rowImm[r];
        dispRs1Busy = rowSrc1[r] >= 0;
        dispRs1Val = rowLit1[r];
        dispRs1Nick = rowSrc1[r] >= 0 ? nickT'(rowSrc1[r]) : '0; // row k holds nick k mod 8.
        dispRs2Busy = rowSrc2[r] >= 0;
        dispRs2Val = rowLit2[r];
        dispRs2Nick = rowSrc2[r] >= 0 ? nickT'(rowSrc2[r]) : '0;
    endtask

    task automatic checkCommit(input int r);
        int bad;
        bad = 0;
        if (commitNick !== nickT'(r)) begin
            $display("ERR commitNick row %0d: got %h, expected %h", r, commitNick, nickT'(r));
            bad++;
        end
        if (commitData !== expData[r]) begin
            $display("ERR commitData row %0d: got %h, expected %h", r, commitData, expData[r]);
            bad++;
        end
        if (commitJump !== expJump[r]) begin
            $display("ERR commitJump row %0d: got %h, expected %h", r, commitJump, expJump[r]);
            bad++;
        end
        if (expJump[r] == Jump && commitJumpPc !== expTarget[r]) begin
            $display("ERR commitJumpPc row %0d: got %h, expected %h", r, commitJumpPc,
                     expTarget[r]);
            bad++;
        end
        $display("row %0d %s: %s", r, rowOp[r].name(), bad == 0 ? "ok" : "mismatch");
        errors += bad;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > TimeoutCycles) begin
            $display("timeout after %0d cycles with %0d of %0d rows committed", cycles,
                     committed, NumRows);
            $display("=== FAIL ===");
            $finish;
        end else if (!rst) begin
            if (full && row >= BurstStart) sawFull = 1'b1;
            if (commit && !rdy) begin
                $display("a commit pulse appeared while rdy was low");
                errors++;
            end
            if (commit && committed >= NumRows) begin
                $display("a commit pulse appeared with no row left to commit");
                errors++;
            end else if (commit) begin
                checkCommit(committed);
                committed++;
            end
        end
    end

    initial begin
        rst = 1'b1;
        rdy = 1'b1;
        disp = 1'b0;
        dispOp = OpLui;
        dispPc = '0;
        dispImm = '0;
        dispRs1Busy = 1'b0;
        dispRs1Val = '0;
        dispRs1Nick = '0;
        dispRs2Busy = 1'b0;
        dispRs2Val = '0;
        dispRs2Nick = '0;
        addRow(OpLui, 32'h1234_5000, Lit, 32'h0, Lit, 32'h0);
        addRow(OpAuipc, 32'h0002_3000, Lit, 32'h0, Lit, 32'h0);
        addRow(OpJal, 32'hffff_ff80, Lit, 32'h0, Lit, 32'h0);
        addRow(OpJalr, 32'h0000_0011, Rnd, 32'h0, Lit, 32'h0);
        addRow(OpBeq, 32'h0000_0040, Lit, 32'h5, Lit, 32'h5);
        addRow(OpBeq, 32'h0000_0044, Lit, 32'h5, Lit, 32'h6);
        addRow(OpBne, 32'h0000_0048, Lit, 32'h7, Lit, 32'h7);
        addRow(OpBne, 32'hffff_fff0, Lit, 32'h1, Lit, 32'h2);
        addRow(OpBlt, 32'h0000_0010, Lit, 32'hffff_fffd, Lit, 32'h2);
        addRow(OpBlt, 32'h0000_0014, Lit, 32'h2, Lit, 32'hffff_fffd);
        addRow(OpBge, 32'h0000_0018, Lit, 32'hffff_fffd, Lit, 32'h2);
        addRow(OpBge, 32'h0000_001c, Lit, 32'h9, Lit, 32'h9);
        addRow(OpBltu, 32'h0000_0020, Lit, 32'hffff_fffd, Lit, 32'h2);
        addRow(OpBltu, 32'hffff_ffe0, Lit, 32'h2, Lit, 32'hffff_fffd);
        addRow(OpBgeu, 32'h0000_0024, Lit, 32'hffff_fffd, Lit, 32'h2);
        addRow(OpBgeu, 32'h0000_0028, Lit, 32'h1, Lit, 32'h2);
        addRow(OpAdd, 32'h0, Rnd, 32'h0, Rnd, 32'h0);
        addRow(OpSub, 32'h0, Rnd, 32'h0, Rnd, 32'h0);
        addRow(OpSll, 32'h0, Rnd, 32'h0, Rnd, 32'h0);
        addRow(OpSlt, 32'h0, Lit, 32'hffff_fff0, Lit, 32'h0000_0010);
        addRow(OpSltu, 32'h0, Lit, 32'hffff_fff0, Lit, 32'h0000_0010);
        addRow(OpXor, 32'h0, Rnd, 32'h0, Rnd, 32'h0);
        addRow(OpSrl, 32'h0, Rnd, 32'h0, Lit, 32'h0000_0043);
        addRow(OpSra, 32'h0, Lit, 32'h8000_1234, Lit, 32'h0000_0124);
        addRow(OpOr, 32'h0, Rnd, 32'h0, Rnd, 32'h0);
        addRow(OpAnd, 32'h0, Rnd, 32'h0, Rnd, 32'h0);
        addRow(OpAddi, 32'h0000_0123, 25, 32'h0, Lit, 32'h0);
        addRow(OpXori, 32'hffff_ff00, 26, 32'h0, Lit, 32'h0);
        addRow(OpOri, 32'h0000_00f0, 27, 32'h0, Lit, 32'h0);
        addRow(OpAndi, 32'hffff_f3c3, 28, 32'h0, Lit, 32'h0);
        addRow(OpSlli, 32'h0000_0025, 29, 32'h0, Lit, 32'h0);
        addRow(OpSrli, 32'h0000_0024, 30, 32'h0, Lit, 32'h0);
        addRow(OpAdd, 32'h0, 31, 32'h0, 29, 32'h0);
        addRow(OpSrai, 32'h0000_0003, 32, 32'h0, Lit, 32'h0);
        addRow(OpSub, 32'h0, 33, 32'h0, 32, 32'h0);
        addRow(OpSra, 32'h0, 34, 32'h0, Lit, 32'h0000_0022);
        addRow(OpSlti, 32'h0000_0100, 35, 32'h0, Lit, 32'h0);
        addRow(OpSltiu, 32'h0000_07ff, Lit, 32'h8000_0000, Lit, 32'h0); // finishes before row 36.
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (row < NumRows) begin
            @(negedge clk);
            rnd = nextRandom();
            rdy = row >= BurstStart || rnd[1:0] != 2'b00; // about one cycle in four is frozen.
            if (rdy && !full) begin
                if (dispNick !== nickT'(row)) begin
                    $display("ERR dispNick row %0d: got %h, expected %h", row, dispNick,
                             nickT'(row));
                    errors++;
                end
                driveRow(row);
                row++;
            end else begin
                disp = 1'b0;
            end
        end
        @(negedge clk);
        disp = 1'b0;
        rdy = 1'b1;
        while (committed < NumRows) @(posedge clk);
        repeat (4) @(posedge clk);
        if (!sawFull) begin
            $display("full never went high during the dispatch burst");
            errors++;
        end else begin
            $display("burst of %0d dispatches raised full: ok", NumRows - BurstStart);
        end
        $display("rows %0d, committed %0d, errors %0d", NumRows, committed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* execCore.f */
hdl/tomasuloPkg.sv
hdl/resStation.sv
hdl/execUnit.sv
hdl/reorderBuf.sv
hdl/execCore.sv
dv/execCoreTb.sv
